/* Bender.yml */
package:
  name: spu_ma_ld

sources:
  - hdl/spu_ma_pkg.sv
  - hdl/spu_ma_ld_if.sv
  - hdl/spu_mald.sv
  - hdl/spu_maaddr.sv
  - hdl/spu_ma_mem.sv
  - hdl/spu_ma_ld_top.sv
  - target: test
    files:
      - tests/tb_spu_ma_ld.sv

/* filelist.f */
hdl/spu_ma_pkg.sv
hdl/spu_ma_ld_if.sv
hdl/spu_mald.sv
hdl/spu_maaddr.sv
hdl/spu_ma_mem.sv
hdl/spu_ma_ld_top.sv
tests/tb_spu_ma_ld.sv

/* hdl/spu_ma_ld_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface spu_ma_ld_if #(
        parameter int MA_ADDR_W = 8
);

        // controller to address unit.
        logic                          load_start;
        logic                          addr_inc;
        logic                          line_sel_latch;

        // address unit back to controller.
        logic                          len_neqz;
        logic                          same_line;

        // current addresses, used by the top and the memory.
        logic [spu_ma_pkg::MPA_W-1:0]  cur_mpa;
        logic [MA_ADDR_W-1:0]          cur_maddr;

        modport ctl (
                output load_start,
                output addr_inc,
                output line_sel_latch,
                input  len_neqz,
                input  same_line
        );

        modport addr (
                input  load_start,
                input  addr_inc,
                input  line_sel_latch,
                output len_neqz,
                output same_line,
                output cur_mpa,
                output cur_maddr
        );

endinterface

`default_nettype wire

/* hdl/spu_ma_ld_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_ma_ld_top #(
        parameter int MA_ADDR_W = spu_ma_pkg::MA_ADDR_W
) (
        input  wire                             rclk,
        input  wire                             rst_n,
        input  wire                             iss,
        input  wire spu_ma_pkg::ma_op_t         op,
        input  wire [spu_ma_pkg::MPA_W-1:0]     start_mpa,
        input  wire [MA_ADDR_W-1:0]             start_maddr,
        input  wire [spu_ma_pkg::LEN_W-1:0]     start_len,
        input  wire                             ldreq_ack,
        input  wire                             ln_received,
        input  wire [spu_ma_pkg::LINE_W-1:0]    ln_data,
        input  wire                             unc_err,
        input  wire                             force_abort,
        input  wire [MA_ADDR_W-1:0]             raddr,
        output logic                            ldreq,
        output logic [spu_ma_pkg::MPA_W-2:0]    req_mpa,
        output logic                            line_rst,
        output logic                            done,
        output logic                            done_set,
        output logic [spu_ma_pkg::WORD_W:0]     rdata
);

        spu_ma_ld_if #(.MA_ADDR_W(MA_ADDR_W)) ld_if ();

        logic u_mem_wen;

        // load control fsm.
        spu_mald u_mald (
                .rclk           (rclk),
                .rst_n          (rst_n),
                .iss            (iss),
                .op             (op),
                .start_len_neqz (|start_len),
                .ldreq_ack      (ldreq_ack),
                .ln_received    (ln_received),
                .unc_err        (unc_err),
                .force_abort    (force_abort),
                .ldreq          (ldreq),
                .wen            (u_mem_wen),
                .line_rst       (line_rst),
                .done           (done),
                .done_set       (done_set),
                .ctl            (ld_if.ctl)
        );

        // address and length counters.
        spu_maaddr #(.MA_ADDR_W(MA_ADDR_W)) u_maaddr (
                .rclk        (rclk),
                .rst_n       (rst_n),
                .start_mpa   (start_mpa),
                .start_maddr (start_maddr),
                .start_len   (start_len),
                .ctl         (ld_if.addr)
        );

        // line buffer, parity stage and scratch memory.
        spu_ma_mem #(.MA_ADDR_W(MA_ADDR_W)) u_mem (
                .rclk        (rclk),
                .rst_n       (rst_n),
                .ln_received (ln_received),
                .ln_data     (ln_data),
                .sel_hi      (ld_if.cur_mpa[0]),
                .waddr       (ld_if.cur_maddr),
                .wen         (u_mem_wen),
                .raddr       (raddr),
                .rdata       (rdata)
        );

        // line address, bits 39 to 4.
        assign req_mpa = ld_if.cur_mpa[spu_ma_pkg::MPA_W-1:1];

endmodule

`default_nettype wire

/* hdl/spu_ma_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_ma_mem #(
        parameter int MA_ADDR_W = 8
) (
        input  wire                             rclk,
        input  wire                             rst_n,
        input  wire                             ln_received,
        input  wire [spu_ma_pkg::LINE_W-1:0]    ln_data,
        input  wire                             sel_hi,
        input  wire [MA_ADDR_W-1:0]             waddr,
        input  wire                             wen,
        input  wire [MA_ADDR_W-1:0]             raddr,
        output logic [spu_ma_pkg::WORD_W:0]     rdata
);

        logic [spu_ma_pkg::LINE_W-1:0] line_q;
        logic [spu_ma_pkg::LINE_W-1:0] line_src;
        logic [spu_ma_pkg::WORD_W-1:0] word_sel;
        logic [spu_ma_pkg::WORD_W-1:0] wd_q;
        logic                          par_q;
        logic [MA_ADDR_W-1:0]          wa_q;
        logic [spu_ma_pkg::WORD_W:0]   mem [0:(1 << MA_ADDR_W)-1];

        // incoming line bypasses the buffer in its arrival cycle.
        assign line_src = ln_received ? ln_data : line_q;
        assign word_sel = sel_hi ? line_src[spu_ma_pkg::LINE_W-1:spu_ma_pkg::WORD_W]
                                 : line_src[spu_ma_pkg::WORD_W-1:0];

        // line buffer and parity stage.
        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        line_q <= '0;
                        wd_q <= '0;
                        par_q <= 1'b0;
                        wa_q <= '0;
                end else begin
                        if (ln_received) begin
                                line_q <= ln_data;
                        end
                        wd_q <= word_sel;
                        // even parity over the word.
                        par_q <= ^word_sel;
                        wa_q <= waddr;
                end
        end

        // scratch memory, parity in the top bit.
        always_ff @(posedge rclk) begin
                if (wen) begin
                        mem[wa_q] <= {par_q, wd_q};
                end
        end

        // asynchronous read port.
        assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* hdl/spu_ma_pkg.sv */
`default_nettype none

package spu_ma_pkg;

        // memory physical address of an 8-byte word, bits 39 to 3.
        localparam int MPA_W = 37;

        // ma scratch memory word index.
        localparam int MA_ADDR_W = 8;

        // load length in 8-byte words.
        localparam int LEN_W = 8;

        // one data word and one memory line.
        localparam int WORD_W = 64;
        localparam int LINE_W = 128;

        // load controller states.
        // mem_wen is the parity cycle ahead of the write.
        typedef enum logic [2:0] {
                idle     = 3'd0,
                ld_req   = 3'd1,
                wait_ln  = 3'd2,
                mem_wen  = 3'd3,
                mem_wr   = 3'd4,
                chk_next = 3'd5
        } ld_state_t;

        // ma opcodes seen with the issue pulse.
        // only op_ld starts a load.
        typedef enum logic [1:0] {
                op_none = 2'd0,
                op_ld   = 2'd1,
                op_st   = 2'd2
        } ma_op_t;

endpackage

`default_nettype wire

/* hdl/spu_maaddr.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_maaddr #(
        parameter int MA_ADDR_W = 8
) (
        input  wire                            rclk,
        input  wire                            rst_n,
        input  wire [spu_ma_pkg::MPA_W-1:0]    start_mpa,
        input  wire [MA_ADDR_W-1:0]            start_maddr,
        input  wire [spu_ma_pkg::LEN_W-1:0]    start_len,
        spu_ma_ld_if.addr                      ctl
);

        logic [spu_ma_pkg::MPA_W-1:0] mpa_q;
        logic [MA_ADDR_W-1:0]         maddr_q;
        logic [spu_ma_pkg::LEN_W-1:0] len_q;
        logic                         line_vld;

        // address counters.
        // loaded at start, stepped once per written word.
        always_ff @(posedge rclk) begin
                if (ctl.load_start) begin
                        mpa_q <= start_mpa;
                        maddr_q <= start_maddr;
                end else if (ctl.addr_inc) begin
                        mpa_q <= mpa_q + 1'b1;
                        maddr_q <= maddr_q + 1'b1;
                end
        end

        // remaining words.
        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        len_q <= '0;
                end else if (ctl.load_start) begin
                        len_q <= start_len;
                end else if (ctl.addr_inc) begin
                        len_q <= len_q - 1'b1;
                end
        end

        // a line is buffered for the current address.
        // stepping past the upper half leaves the line.
        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        line_vld <= 1'b0;
                end else if (ctl.load_start) begin
                        line_vld <= 1'b0;
                end else if (ctl.line_sel_latch) begin
                        line_vld <= 1'b1;
                end else if (ctl.addr_inc && mpa_q[0]) begin
                        line_vld <= 1'b0;
                end
        end

        // mpa bit 0 is address bit 3, the upper half of the line.
        assign ctl.same_line = mpa_q[0] & line_vld;
        assign ctl.len_neqz = |len_q;
        assign ctl.cur_mpa = mpa_q;
        assign ctl.cur_maddr = maddr_q;

endmodule

`default_nettype wire

/* hdl/spu_mald.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_mald (
        input  wire                     rclk,
        input  wire                     rst_n,
        input  wire                     iss,
        input  wire spu_ma_pkg::ma_op_t op,
        input  wire                     start_len_neqz,
        input  wire                     ldreq_ack,
        input  wire                     ln_received,
        input  wire                     unc_err,
        input  wire                     force_abort,
        output logic                    ldreq,
        output logic                    wen,
        output logic                    line_rst,
        output logic                    done,
        output logic                    done_set,
        spu_ma_ld_if.ctl                ctl
);

        spu_ma_pkg::ld_state_t state;
        spu_ma_pkg::ld_state_t state_nxt;
        logic                  start_ld;
        logic                  busy;
        logic                  wen_st;
        logic                  unc_hit;
        logic                  abort_hit;
        logic                  ld_op;

        // a load starts only from idle with the load opcode.
        assign start_ld = iss & (op == spu_ma_pkg::op_ld) & (state == spu_ma_pkg::idle);
        assign busy = (state != spu_ma_pkg::idle);

        // parity cycle; the word is written at its end.
        assign wen_st = (state == spu_ma_pkg::mem_wen);

        // uncorrectable error ends any busy state.
        assign unc_hit = busy & unc_err;

        // abort is only looked at during the parity cycle.
        assign abort_hit = wen_st & force_abort;

        always_comb begin
                state_nxt = state;
                case (state)
                        spu_ma_pkg::idle: begin
                                // zero length goes straight to the length check.
                                if (start_ld && start_len_neqz) begin
                                        state_nxt = spu_ma_pkg::ld_req;
                                end else if (start_ld) begin
                                        state_nxt = spu_ma_pkg::chk_next;
                                end
                        end
                        spu_ma_pkg::ld_req: begin
                                // hold the request until acked.
                                if (ldreq_ack) begin
                                        state_nxt = spu_ma_pkg::wait_ln;
                                end
                        end
                        spu_ma_pkg::wait_ln: begin
                                if (ln_received) begin
                                        state_nxt = spu_ma_pkg::mem_wen;
                                end
                        end
                        spu_ma_pkg::mem_wen: begin
                                state_nxt = spu_ma_pkg::mem_wr;
                        end
                        spu_ma_pkg::mem_wr: begin
                                state_nxt = spu_ma_pkg::chk_next;
                        end
                        spu_ma_pkg::chk_next: begin
                                // upper half of a buffered line needs no request.
                                if (!ctl.len_neqz) begin
                                        state_nxt = spu_ma_pkg::idle;
                                end else if (ctl.same_line) begin
                                        state_nxt = spu_ma_pkg::mem_wen;
                                end else begin
                                        state_nxt = spu_ma_pkg::ld_req;
                                end
                        end
                        default: begin
                                state_nxt = spu_ma_pkg::idle;
                        end
                endcase
                // errors win over every transition.
                if (unc_hit || abort_hit) begin
                        state_nxt = spu_ma_pkg::idle;
                end
        end

        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        state <= spu_ma_pkg::idle;
                end else begin
                        state <= state_nxt;
                end
        end

        // opcode of the last issue seen while idle.
        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        ld_op <= 1'b0;
                end else if (iss && !busy) begin
                        ld_op <= (op == spu_ma_pkg::op_ld);
                end
        end

        // sticky done flag.
        // cleared by the next issue, set by done or an early end.
        always_ff @(posedge rclk) begin
                if (!rst_n) begin
                        done_set <= 1'b0;
                end else if (iss) begin
                        done_set <= 1'b0;
                end else if ((done || unc_hit || abort_hit) && ld_op) begin
                        done_set <= 1'b1;
                end
        end

        assign done = (state == spu_ma_pkg::chk_next) & ~ctl.len_neqz;
        assign ldreq = (state == spu_ma_pkg::ld_req);

        // an uncorrectable error also drops the pending write.
        assign wen = wen_st & ~unc_err;

        // one pulse per written word, plus one on an early end.
        assign line_rst = ((state == spu_ma_pkg::mem_wr) & ctl.len_neqz) | abort_hit | unc_hit;

        assign ctl.load_start = start_ld;
        assign ctl.addr_inc = (state == spu_ma_pkg::mem_wr);
        assign ctl.line_sel_latch = (state == spu_ma_pkg::wait_ln) & ln_received;

endmodule

`default_nettype wire

/* tests/spu_ma_ld_vectors.txt */
// op(1 ld, 2 st, 0 none) start_mpa start_maddr len err_word err_kind(1 unc, 2 abort) exp_words
// all hex; an op of f ends the list.
1 0000000100 00 10 00 0 10
1 0000000201 20 07 00 0 07
1 0000000300 40 00 00 0 00
2 0000000300 00 04 00 0 00
1 0000001000 60 20 00 0 20
1 0000002000 60 0c 05 1 05
1 0000003001 68 0c 06 2 07
1 0000004000 70 04 00 1 00
1 0000005003 78 03 00 2 01
1 0000000701 70 08 02 1 02
1 1ffffffffc fc 08 00 0 08
1 0000000400 80 05 00 0 05
0 0000000500 80 05 00 0 00
1 0000000601 90 01 00 0 01
1 000abcdef0 a0 20 00 0 20
2 0000000000 a0 08 00 0 00
1 0000000800 b0 02 01 2 02
1 0000000900 b8 03 02 1 02
f 0000000000 00 00 00 0 00

/* tests/tb_spu_ma_ld.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spu_ma_ld;

        localparam int MA_ADDR_W = 8;
        localparam int MEM_D = 1 << MA_ADDR_W;
        localparam int MAX_TESTS = 64;
        localparam int VEC_COLS = 7;

        logic                             rclk;
        logic                             rst_n;
        logic                             iss;
        spu_ma_pkg::ma_op_t               op;
        logic [spu_ma_pkg::MPA_W-1:0]     start_mpa;
        logic [MA_ADDR_W-1:0]             start_maddr;
        logic [spu_ma_pkg::LEN_W-1:0]     start_len;
        logic                             ldreq_ack;
        logic                             ln_received;
        logic [spu_ma_pkg::LINE_W-1:0]    ln_data;
        logic                             unc_err;
        logic                             force_abort;
        logic [MA_ADDR_W-1:0]             raddr;
        logic                             ldreq;
        logic [spu_ma_pkg::MPA_W-2:0]     req_mpa;
        logic                             line_rst;
        logic                             done;
        logic                             done_set;
        logic [spu_ma_pkg::WORD_W:0]      rdata;

        // seven vector columns per test.
        logic [39:0]                      vec_mem [0:MAX_TESTS*VEC_COLS-1];

        // expected scratch memory, valid once written.
        logic [spu_ma_pkg::WORD_W:0]      exp_mem [0:MEM_D-1];
        logic                             exp_vld [0:MEM_D-1];

        logic [31:0]                      lfsr;
        int                               err_cnt;
        int                               cycle_cnt;
        int                               cycle_limit;
        int                               n_tests;
        int                               n_pass;

        spu_ma_ld_top #(.MA_ADDR_W(MA_ADDR_W)) uut (
                .rclk        (rclk),
                .rst_n       (rst_n),
                .iss         (iss),
                .op          (op),
                .start_mpa   (start_mpa),
                .start_maddr (start_maddr),
                .start_len   (start_len),
                .ldreq_ack   (ldreq_ack),
                .ln_received (ln_received),
                .ln_data     (ln_data),
                .unc_err     (unc_err),
                .force_abort (force_abort),
                .raddr       (raddr),
                .ldreq       (ldreq),
                .req_mpa     (req_mpa),
                .line_rst    (line_rst),
                .done        (done),
                .done_set    (done_set),
                .rdata       (rdata)
        );

        initial rclk = 1'b0;
        always #5 rclk = ~rclk;

        // run limit from the vector lengths.
        always @(posedge rclk) begin
                cycle_cnt = cycle_cnt + 1;
                if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
                        $display("timeout: the run took more than %0d cycles", cycle_limit);
                        $display("sim failed");
                        $finish;
                end
        end

        // fibonacci lfsr, taps 32 22 2 1, one step per bit.
        function automatic int draw_bits(input int n);
                int i;
                int v;
                v = 0;
                for (i = 0; i < n; i++) begin
                        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
                        v = (v << 1) | lfsr[0];
                end
                return v;
        endfunction

        // memory side line content, mixed from the line address.
        function automatic logic [spu_ma_pkg::LINE_W-1:0] line_pattern(input logic [35:0] la);
                logic [63:0] a;
                logic [63:0] lo;
                logic [63:0] hi;
                a = {28'd0, la};
                lo = (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0123_4567_89ab_cdef;
                hi = {lo[31:0], lo[63:32]} ^ (a << 23) ^ 64'hf0e1_d2c3_b4a5_9687;
                return {hi, lo};
        endfunction

        // bit 0 of the word address picks the line half.
        function automatic logic [spu_ma_pkg::WORD_W-1:0] word_at(
                input logic [spu_ma_pkg::MPA_W-1:0] mpa);
                logic [spu_ma_pkg::LINE_W-1:0] ln;
                ln = line_pattern(mpa[spu_ma_pkg::MPA_W-1:1]);
                return mpa[0] ? ln[127:64] : ln[63:0];
        endfunction

        task automatic run_test(input int t);
                int                            b;
                int                            i;
                int                            len;
                int                            err_word;
                int                            err_kind;
                int                            exp_words;
                int                            rule_words;
                int                            exp_att;
                int                            exp_req;
                int                            n_att;
                int                            n_req;
                int                            n_lrst;
                int                            n_done;
                int                            ack_wait;
                int                            line_wait;
                int                            cyc;
                int                            errs_before;
                logic                          is_ld;
                logic                          ldreq_prev;
                logic                          ack_prev;
                logic                          ln_prev;
                logic                          line_pend;
                logic                          stop_wr;
                logic                          wen_due;
                logic                          fin;
                logic [2:0]                    wen_hist;
                logic [35:0]                   line_la;
                logic [spu_ma_pkg::MPA_W-1:0]  mpa;
                logic [spu_ma_pkg::MPA_W-1:0]  a;
                logic [spu_ma_pkg::WORD_W-1:0] w;
                logic [MA_ADDR_W-1:0]          maddr;
                logic [MA_ADDR_W-1:0]          ra;

                b = t * VEC_COLS;
                errs_before = err_cnt;
                is_ld = (vec_mem[b][1:0] == 2'd1);
                mpa = vec_mem[b+1][spu_ma_pkg::MPA_W-1:0];
                maddr = vec_mem[b+2][MA_ADDR_W-1:0];
                len = int'(vec_mem[b+3][spu_ma_pkg::LEN_W-1:0]);
                err_word = int'(vec_mem[b+4][7:0]);
                err_kind = int'(vec_mem[b+5][1:0]);
                exp_words = int'(vec_mem[b+6][7:0]);

                // words reaching the write cycle, and words kept.
                exp_att = 0;
                rule_words = 0;
                if (is_ld && len > 0 && err_kind != 0) begin
                        exp_att = err_word + 1;
                        rule_words = (err_kind == 1) ? err_word : err_word + 1;
                end else if (is_ld) begin
                        exp_att = len;
                        rule_words = len;
                end
                assert (exp_words == rule_words && (err_kind == 0 || err_word < len)) else begin
                        $display("vector %0d does not agree with the load rules", t);
                        err_cnt++;
                end

                // one request per distinct line touched.
                exp_req = 0;
                for (i = 0; i < exp_att; i++) begin
                        a = mpa + i;
                        if (i == 0 || !a[0]) begin
                                exp_req++;
                        end
                end

                // issue cycle.
                @(posedge rclk);
                #1;
                iss = 1'b1;
                op = spu_ma_pkg::ma_op_t'(vec_mem[b][1:0]);
                start_mpa = mpa;
                start_maddr = maddr;
                start_len = len[spu_ma_pkg::LEN_W-1:0];

                ldreq_prev = 1'b0;
                ack_prev = 1'b0;
                ln_prev = 1'b0;
                line_pend = 1'b0;
                stop_wr = 1'b0;
                wen_hist = '0;
                line_la = '0;
                n_att = 0;
                n_req = 0;
                n_lrst = 0;
                n_done = 0;
                ack_wait = 0;
                line_wait = 0;
                cyc = 0;
                fin = 1'b0;
                while (!fin) begin
                        @(posedge rclk);
                        #1;
                        iss = 1'b0;
                        ldreq_ack = 1'b0;
                        ln_received = 1'b0;
                        ln_data = '0;
                        unc_err = 1'b0;
                        force_abort = 1'b0;
                        // request level held until acked.
                        if (ldreq_prev && !ack_prev) begin
                                assert (ldreq) else begin
                                        $display("FAILED %0t: test %0d ldreq dropped before ack",
                                                 $time, t);
                                        err_cnt++;
                                end
                        end
                        if (ldreq && !ldreq_prev) begin
                                n_req++;
                                a = mpa + n_att;
                                assert (req_mpa === a[spu_ma_pkg::MPA_W-1:1]) else begin
                                        $display("FAILED %0t: test %0d req_mpa %h expected %h",
                                                 $time, t, req_mpa, a[spu_ma_pkg::MPA_W-1:1]);
                                        err_cnt++;
                                end
                                ack_wait = draw_bits(2);
                        end
                        // memory side: ack, then the line some cycles later.
                        if (ldreq) begin
                                if (ack_wait == 0) begin
                                        ldreq_ack = 1'b1;
                                        line_la = req_mpa;
                                        line_wait = draw_bits(2);
                                        line_wait = line_wait + 1;
                                        line_pend = 1'b1;
                                end else begin
                                        ack_wait--;
                                end
                        end else if (line_pend) begin
                                line_wait--;
                                if (line_wait == 0) begin
                                        ln_received = 1'b1;
                                        ln_data = line_pattern(line_la);
                                        line_pend = 1'b0;
                                end
                        end
                        // write cycle follows a line, or a same-line check
                        // three cycles after a lower half write.
                        a = mpa + n_att - 1;
                        wen_due = !stop_wr && (ln_prev ||
                                  (wen_hist[2] && n_att > 0 && !a[0] && n_att < len));
                        if (wen_due) begin
                                if (err_kind != 0 && n_att == err_word) begin
                                        unc_err = (err_kind == 1);
                                        force_abort = (err_kind == 2);
                                        stop_wr = 1'b1;
                                end
                                n_att++;
                        end
                        wen_hist = {wen_hist[1:0], wen_due};
                        ldreq_prev = ldreq;
                        ack_prev = ldreq_ack;
                        ln_prev = ln_received;
                        @(negedge rclk);
                        if (line_rst) begin
                                n_lrst++;
                        end
                        if (done) begin
                                n_done++;
                        end
                        cyc++;
                        // non-load ops just get a quiet window.
                        fin = is_ld ? done_set : (cyc >= 8);
                end

                assert (n_req == exp_req) else begin
                        $display("FAILED %0t: test %0d saw %0d requests, expected %0d",
                                 $time, t, n_req, exp_req);
                        err_cnt++;
                end
                assert (n_lrst == exp_att) else begin
                        $display("FAILED %0t: test %0d saw %0d line_rst pulses, expected %0d",
                                 $time, t, n_lrst, exp_att);
                        err_cnt++;
                end
                assert (n_done == ((is_ld && err_kind == 0) ? 1 : 0)) else begin
                        $display("FAILED %0t: test %0d saw %0d done pulses", $time, t, n_done);
                        err_cnt++;
                end

                // model update.
                for (i = 0; i < exp_words; i++) begin
                        a = mpa + i;
                        w = word_at(a);
                        ra = maddr + i;
                        exp_mem[ra] = {^w, w};
                        exp_vld[ra] = 1'b1;
                end

                // readback over the whole range.
                for (i = 0; i < len; i++) begin
                        @(posedge rclk);
                        #1;
                        ra = maddr + i;
                        raddr = ra;
                        @(negedge rclk);
                        if (exp_vld[ra]) begin
                                assert (rdata === exp_mem[ra]) else begin
                                        $display("FAILED %0t: test %0d addr %h read %h expected %h",
                                                 $time, t, ra, rdata, exp_mem[ra]);
                                        err_cnt++;
                                end
                        end
                end
                // sticky flag still as it was after the end.
                assert (done_set === is_ld) else begin
                        $display("FAILED %0t: test %0d done_set %b expected %b",
                                 $time, t, done_set, is_ld);
                        err_cnt++;
                end

                if (err_cnt == errs_before) begin
                        n_pass++;
                        $display("test %0d: ok", t);
                end else begin
                        $display("test %0d: %0d check(s) failed", t, err_cnt - errs_before);
                end
        endtask

        initial begin
                int t;
                rst_n = 1'b0;
                iss = 1'b0;
                op = spu_ma_pkg::op_none;
                start_mpa = '0;
                start_maddr = '0;
                start_len = '0;
                ldreq_ack = 1'b0;
                ln_received = 1'b0;
                ln_data = '0;
                unc_err = 1'b0;
                force_abort = 1'b0;
                raddr = '0;
                lfsr = 32'h6ac4;
                err_cnt = 0;
                cycle_cnt = 0;
                cycle_limit = 0;
                n_tests = 0;
                n_pass = 0;
                for (t = 0; t < MEM_D; t++) begin
                        exp_vld[t] = 1'b0;
                end

                // list ends at an op column of f.
                $readmemh("tests/spu_ma_ld_vectors.txt", vec_mem);
                while (n_tests < MAX_TESTS && vec_mem[n_tests*VEC_COLS][3:0] !== 4'hf) begin
                        cycle_limit += 40 * int'(vec_mem[n_tests*VEC_COLS+3][7:0]) + 100;
                        n_tests++;
                end
                cycle_limit += 20;
                assert (n_tests > 0) else begin
                        $display("no test vectors were read");
                        err_cnt++;
                end

                repeat (10) @(posedge rclk);
                #1;
                rst_n = 1'b1;

                for (t = 0; t < n_tests; t++) begin
                        run_test(t);
                end

                $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                         n_tests, n_pass, n_tests - n_pass, err_cnt);
                if (err_cnt == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

`default_nettype wire
